/* dv/jackal_shell_testdata.txt */
// kind 1 download: 1 AAA DD (byte address, data); kinds 2 and 3 cpu/gfx read: k AAA 00 (word)
// kind 4 rotary: 4 P D 0 NN (player, direction 0 left 1 right, held steps)
100055
1001aa
100266
100334
100212
17fec3
17ff3c
180081
1c007e
18a5e1
1ca51e
200000
200100
23ff00
300000
30a500
410003
421005
411002

/* jackal_shell.f */
common/shell_pkg.sv
common/rom_wr_if.sv
hw/shell_ctrl.sv
hw/rom/rom_loader.sv
hw/rom/rom_bank.sv
hw/rotary_encoder.sv
hw/jackal_shell.sv
dv/shell_clkgen.sv
dv/tb_jackal_shell.sv

/* dv/tb_jackal_shell.sv */
`timescale 1ns/1ps

module tb_jackal_shell import shell_pkg::*; ();

	localparam int MAX_ENTRIES = 64;

	logic              clock_49;
	logic              arst_n;
	logic              ioctl_download;
	logic              ioctl_wr;
	logic [DL_AW-1:0]  ioctl_addr;
	logic [7:0]        ioctl_dout;
	logic [7:0]        status;
	logic [1:0]        buttons;
	logic [1:0]        core_mod;
	logic              p1_left;
	logic              p1_right;
	logic              p2_left;
	logic              p2_right;
	logic [CPU_AW-1:0] cpu_rom_addr;
	logic [GFX_AW-1:0] gfx_rom_addr;
	cpu_word_t         cpu_rom_do;
	gfx_word_t         gfx_rom_do;
	logic [7:0]        p1_rotary;
	logic [7:0]        p2_rotary;
	logic              core_reset;
	logic              led;

	// record kind in the top hex digit
	logic [23:0] tdata [MAX_ENTRIES];
	logic [15:0] cpu_model [2**CPU_AW];
	logic [15:0] gfx_model [2**GFX_AW];
	logic [7:0]  pos_model [1:2];
	logic [15:0] lfsr_state;
	int          n_entries;
	int          n_steps;
	int          limit_cycles = 0;
	int          n_checks;
	int          n_errors;

	shell_clkgen clkgen (
		.clock_49 (clock_49),
		.arst_n   (arst_n)
	);

	jackal_shell dut0 (
		.clock_49       (clock_49),
		.arst_n         (arst_n),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.status         (status),
		.buttons        (buttons),
		.core_mod       (core_mod),
		.p1_left        (p1_left),
		.p1_right       (p1_right),
		.p2_left        (p2_left),
		.p2_right       (p2_right),
		.cpu_rom_addr   (cpu_rom_addr),
		.gfx_rom_addr   (gfx_rom_addr),
		.cpu_rom_do     (cpu_rom_do),
		.gfx_rom_do     (gfx_rom_do),
		.p1_rotary      (p1_rotary),
		.p2_rotary      (p2_rotary),
		.core_reset     (core_reset),
		.led            (led)
	);

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		n_checks++;
		if (actual !== expected) begin
			n_errors++;
			$display("Error %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	// galois form with taps at 16 14 13 11
	function automatic logic lfsr_bit();
		logic out;
		out = lfsr_state[0];
		lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hB400) : (lfsr_state >> 1);
		return out;
	endfunction

	task automatic random_wait();
		int n;
		n = 0;
		for (int i = 0; i < 3; i++) begin
			n = (n << 1) | lfsr_bit();
		end
		repeat (n + 1) @(posedge clock_49);
	endtask

	// expected bank contents from the lane rules
	task automatic model_write(input logic [DL_AW-1:0] addr, input logic [7:0] data);
		logic [DL_AW-1:0] off;
		if (addr < GFX_BASE) begin
			cpu_model[addr[CPU_AW:1]][8*addr[0] +: 8] = data;
		end else begin
			off = addr - DL_AW'(GFX_BASE);
			gfx_model[off[GFX_AW-1:0]][8*off[GFX_LANE_BIT] +: 8] = data;
		end
	endtask

	task automatic load_byte(input logic [DL_AW-1:0] addr, input logic [7:0] data);
		@(posedge clock_49);
		ioctl_addr <= addr;
		ioctl_dout <= data;
		ioctl_wr   <= 1'b1;
		repeat (2) @(posedge clock_49);
		ioctl_wr <= 1'b0;
		@(posedge clock_49);
		model_write(addr, data);
		@(negedge clock_49);
		check_value("reset_in_download", 1, core_reset);
		check_value("led_in_download", 0, led);
	endtask

	task automatic read_cpu(input logic [CPU_AW-1:0] addr);
		@(posedge clock_49);
		cpu_rom_addr <= addr;
		@(posedge clock_49);
		@(negedge clock_49);
		check_value($sformatf("cpu_read[%0h]", addr), cpu_model[addr], cpu_rom_do);
	endtask

	task automatic read_gfx(input logic [GFX_AW-1:0] addr);
		@(posedge clock_49);
		gfx_rom_addr <= addr;
		@(posedge clock_49);
		@(negedge clock_49);
		check_value($sformatf("gfx_read[%0h]", addr), gfx_model[addr], gfx_rom_do);
	endtask

	task automatic reset_source(input string name, input logic use_button);
		@(posedge clock_49);
		if (use_button) buttons[1] <= 1'b1;
		else status[0] <= 1'b1;
		repeat (2) @(posedge clock_49);
		@(negedge clock_49);
		check_value({name, "_set"}, 1, core_reset);
		@(posedge clock_49);
		if (use_button) buttons[1] <= 1'b0;
		else status[0] <= 1'b0;
		repeat (2) @(posedge clock_49);
		@(negedge clock_49);
		check_value({name, "_clear"}, 0, core_reset);
	endtask

	function automatic logic [7:0] rot_out(input int player);
		return (player == 1) ? p1_rotary : p2_rotary;
	endfunction

	// left moves toward the high bit
	function automatic logic [7:0] rot_next(input logic [7:0] pos, input logic left);
		return left ? {pos[6:0], pos[7]} : {pos[0], pos[7:1]};
	endfunction

	task automatic set_stick(input int player, input logic left, input logic value);
		if (player == 1 && left) p1_left <= value;
		else if (player == 1) p1_right <= value;
		else if (left) p2_left <= value;
		else p2_right <= value;
	endtask

	task automatic watch_rotary(input int player, input logic left, input int cycles,
			output int steps);
		logic [7:0] cur;
		steps = 0;
		repeat (cycles) begin
			@(negedge clock_49);
			cur = rot_out(player);
			if (cur !== pos_model[player]) begin
				check_value("rotary_step", rot_next(pos_model[player], left), cur);
				pos_model[player] = rot_next(pos_model[player], left);
				steps++;
			end
		end
	endtask

	task automatic run_script(input int player, input logic left, input int count);
		logic [7:0] expected;
		int         steps;
		int         got;
		expected = pos_model[player];
		repeat (count) expected = rot_next(expected, left);
		steps = 0;
		@(posedge clock_49);
		set_stick(player, left, 1'b1);
		while (steps < count) begin
			watch_rotary(player, left, 1, got);
			steps += got;
		end
		@(posedge clock_49);
		set_stick(player, left, 1'b0);
		@(negedge clock_49);
		check_value($sformatf("rotary_final_p%0d", player), expected, rot_out(player));
	endtask

	initial begin
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge clock_49);
		$display("Run timed out after %0d cycles without finishing", limit_cycles);
		$display("SOME TESTS FAILED");
		$finish;
	end

	initial begin
		int kind;
		int got;
		ioctl_download = 1'b0;
		ioctl_wr       = 1'b0;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		status         = '0;
		buttons        = '0;
		core_mod       = '0;
		p1_left        = 1'b0;
		p1_right       = 1'b0;
		p2_left        = 1'b0;
		p2_right       = 1'b0;
		cpu_rom_addr   = '0;
		gfx_rom_addr   = '0;
		n_checks       = 0;
		n_errors       = 0;
		lfsr_state     = 16'd19;
		pos_model[1]   = 8'h01;
		pos_model[2]   = 8'h01;
		for (int i = 0; i < MAX_ENTRIES; i++) tdata[i] = '0;
		$readmemh("dv/jackal_shell_testdata.txt", tdata);
		n_entries = 0;
		n_steps = 0;
		while (n_entries < MAX_ENTRIES && tdata[n_entries][23:20] != 0) begin
			if (tdata[n_entries][23:20] == 4) n_steps += tdata[n_entries][7:0];
			n_entries++;
		end
		limit_cycles = n_entries * 8 + n_steps * (2**ROT_DIV_SLOW) * 2 + 2000;

		wait (arst_n === 1'b1);
		@(negedge clock_49);
		check_value("reset_core", 1, core_reset);
		check_value("reset_led", 1, led);
		check_value("reset_p1", 8'h01, p1_rotary);
		check_value("reset_p2", 8'h01, p2_rotary);

		@(posedge clock_49);
		ioctl_download <= 1'b1;
		for (int i = 0; i < n_entries; i++) begin
			if (tdata[i][23:20] == 1) load_byte(tdata[i][19:8], tdata[i][7:0]);
		end
		@(posedge clock_49);
		ioctl_download <= 1'b0;
		@(negedge clock_49);
		check_value("led_after_download", 1, led);
		check_value("release_cycle1", 1, core_reset);
		@(negedge clock_49);
		check_value("release_cycle2", 1, core_reset);
		@(negedge clock_49);
		check_value("release_done", 0, core_reset);
		random_wait();

		for (int i = 0; i < n_entries; i++) begin
			kind = tdata[i][23:20];
			if (kind == 2) read_cpu(tdata[i][8 +: CPU_AW]);
			else if (kind == 3) read_gfx(tdata[i][8 +: GFX_AW]);
		end
		random_wait();

		reset_source("status_reset", 1'b0);
		reset_source("button_reset", 1'b1);
		random_wait();

		for (int i = 0; i < n_entries; i++) begin
			if (tdata[i][23:20] == 4) begin
				run_script(tdata[i][19:16], tdata[i][15:12] == 0, tdata[i][7:0]);
				random_wait();
			end
		end

		// fast step rate on player 1
		@(posedge clock_49);
		status[1] <= 1'b1;
		set_stick(1, 1'b1, 1'b1);
		watch_rotary(1, 1'b1, 2**ROT_DIV_SLOW, got);
		check_value("fast_rate", 1, got >= 2);
		@(posedge clock_49);
		status[1] <= 1'b0;
		set_stick(1, 1'b1, 1'b0);
		watch_rotary(1, 1'b1, 4, got);

		@(posedge clock_49);
		core_mod <= 2'b01;
		@(negedge clock_49);
		check_value("bootleg_p1", 8'hFF, p1_rotary);
		check_value("bootleg_p2", 8'hFF, p2_rotary);
		// exactly one slow tick falls inside this hold
		@(posedge clock_49);
		set_stick(1, 1'b1, 1'b1);
		repeat (2**ROT_DIV_SLOW) @(posedge clock_49);
		set_stick(1, 1'b1, 1'b0);
		pos_model[1] = rot_next(pos_model[1], 1'b1);
		@(negedge clock_49);
		check_value("bootleg_hold_p1", 8'hFF, p1_rotary);
		@(posedge clock_49);
		core_mod <= 2'b00;
		@(negedge clock_49);
		check_value("bootleg_off_p1", pos_model[1], p1_rotary);
		check_value("bootleg_off_p2", pos_model[2], p2_rotary);

		$display("checks: %0d, errors: %0d", n_checks, n_errors);
		if (n_errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

/* dv/shell_clkgen.sv */
`timescale 1ns/1ps

module shell_clkgen (
	output logic clock_49,
	output logic arst_n
);

	// 20 ns period
	initial begin
		clock_49 = 1'b0;
		forever #10 clock_49 = ~clock_49;
	end

	initial begin
		arst_n = 1'b0;
		repeat (16) @(posedge clock_49);
		arst_n <= 1'b1;
	end

endmodule

/* hw/jackal_shell.sv */
`timescale 1ns/1ps

module jackal_shell import shell_pkg::*; (
	input  logic              clock_49,
	input  logic              arst_n,
	input  logic              ioctl_download,
	input  logic              ioctl_wr,
	input  logic [DL_AW-1:0]  ioctl_addr,
	input  logic [7:0]        ioctl_dout,
	input  logic [7:0]        status,
	input  logic [1:0]        buttons,
	input  logic [1:0]        core_mod,
	input  logic              p1_left,
	input  logic              p1_right,
	input  logic              p2_left,
	input  logic              p2_right,
	input  logic [CPU_AW-1:0] cpu_rom_addr,
	input  logic [GFX_AW-1:0] gfx_rom_addr,
	output cpu_word_t         cpu_rom_do,
	output gfx_word_t         gfx_rom_do,
	output logic [7:0]        p1_rotary,
	output logic [7:0]        p2_rotary,
	output logic              core_reset,
	output logic              led
);

	logic rot_tick;
	logic bootleg;

	rom_wr_if cpu_wr ();
	rom_wr_if gfx_wr ();

	shell_ctrl ctrl (
		.clock_49       (clock_49),
		.arst_n         (arst_n),
		.ioctl_download (ioctl_download),
		.status         (status),
		.buttons        (buttons),
		.core_mod       (core_mod),
		.core_reset     (core_reset),
		.led            (led),
		.rot_tick       (rot_tick),
		.bootleg        (bootleg)
	);

	rom_loader loader (
		.clock_49   (clock_49),
		.arst_n     (arst_n),
		.ioctl_wr   (ioctl_wr),
		.ioctl_addr (ioctl_addr),
		.ioctl_dout (ioctl_dout),
		.cpu_wr     (cpu_wr),
		.gfx_wr     (gfx_wr)
	);

	rom_bank #(.word_t(cpu_word_t), .AW(CPU_AW)) cpu_bank (
		.clock_49 (clock_49),
		.wr       (cpu_wr),
		.rd_addr  (cpu_rom_addr),
		.rd_data  (cpu_rom_do)
	);

	rom_bank #(.word_t(gfx_word_t), .AW(GFX_AW)) gfx_bank (
		.clock_49 (clock_49),
		.wr       (gfx_wr),
		.rd_addr  (gfx_rom_addr),
		.rd_data  (gfx_rom_do)
	);

	rotary_encoder rot_p1 (
		.clock_49 (clock_49),
		.arst_n   (arst_n),
		.tick     (rot_tick),
		.left     (p1_left),
		.right    (p1_right),
		.bootleg  (bootleg),
		.position (p1_rotary)
	);

	rotary_encoder rot_p2 (
		.clock_49 (clock_49),
		.arst_n   (arst_n),
		.tick     (rot_tick),
		.left     (p2_left),
		.right    (p2_right),
		.bootleg  (bootleg),
		.position (p2_rotary)
	);

endmodule

/* hw/rotary_encoder.sv */
`timescale 1ns/1ps

module rotary_encoder import shell_pkg::*; (
	input  logic       clock_49,
	input  logic       arst_n,
	input  logic       tick,
	input  logic       left,
	input  logic       right,
	input  logic       bootleg,
	output logic [7:0] position
);

	logic [7:0] rot_pos;

	// one step per tick, left wins when both are held
	always_ff @(posedge clock_49 or negedge arst_n) begin
		if (!arst_n) begin
			rot_pos <= ROT_HOME;
		end else if (tick) begin
			if (left) begin
				rot_pos <= {rot_pos[6:0], rot_pos[7]};
			end else if (right) begin
				rot_pos <= {rot_pos[0], rot_pos[7:1]};
			end
		end
	end

	// bootleg boards have no encoder, so the core sees all ones
	assign position = bootleg ? 8'hFF : rot_pos;

endmodule

/* hw/rom/rom_bank.sv */
`timescale 1ns/1ps

module rom_bank #(
	parameter type word_t = logic [15:0],
	parameter int  AW     = 10
) (
	input  logic          clock_49,
	rom_wr_if.dst         wr,
	input  logic [AW-1:0] rd_addr,
	output word_t         rd_data
);

	// two byte lanes per word so each lane can be written alone
	logic [1:0][7:0] mem [2**AW];
	logic [AW-1:0]   wr_addr;

	assign wr_addr = wr.addr[AW-1:0];

	always_ff @(posedge clock_49) begin
		if (wr.we) begin
			if (wr.ds[0]) begin
				mem[wr_addr][0] <= wr.data[7:0];
			end
			if (wr.ds[1]) begin
				mem[wr_addr][1] <= wr.data[15:8];
			end
		end
	end

	// one cycle read latency
	always_ff @(posedge clock_49) begin
		rd_data <= word_t'(mem[rd_addr]);
	end

endmodule

/* hw/rom/rom_loader.sv */
`timescale 1ns/1ps

module rom_loader import shell_pkg::*; (
	input  logic             clock_49,
	input  logic             arst_n,
	input  logic             ioctl_wr,
	input  logic [DL_AW-1:0] ioctl_addr,
	input  logic [7:0]       ioctl_dout,
	rom_wr_if.src            cpu_wr,
	rom_wr_if.src            gfx_wr
);

	logic             wr_d;
	logic             wr_rise;
	logic             is_gfx;
	logic [DL_AW-1:0] gfx_off;

	assign wr_rise = ioctl_wr & ~wr_d;
	assign is_gfx  = (ioctl_addr >= DL_AW'(GFX_BASE));
	assign gfx_off = ioctl_addr - DL_AW'(GFX_BASE);

	// one write strobe per loader byte
	always_ff @(posedge clock_49 or negedge arst_n) begin
		if (!arst_n) begin
			wr_d      <= 1'b0;
			cpu_wr.we <= 1'b0;
			gfx_wr.we <= 1'b0;
		end else begin
			wr_d      <= ioctl_wr;
			cpu_wr.we <= wr_rise & ~is_gfx;
			gfx_wr.we <= wr_rise & is_gfx;
		end
	end

	// cpu bytes pair up on address bit 0
	always_ff @(posedge clock_49) begin
		if (wr_rise) begin
			cpu_wr.addr <= ioctl_addr[CPU_AW:1];
			cpu_wr.ds   <= {ioctl_addr[0], ~ioctl_addr[0]};
			cpu_wr.data <= {ioctl_dout, ioctl_dout};
		end
	end

	// the upper half of the gfx region becomes plane_hi of the same words
	always_ff @(posedge clock_49) begin
		if (wr_rise) begin
			gfx_wr.addr <= gfx_off[GFX_AW-1:0];
			gfx_wr.ds   <= {gfx_off[GFX_LANE_BIT], ~gfx_off[GFX_LANE_BIT]};
			gfx_wr.data <= {ioctl_dout, ioctl_dout};
		end
	end

endmodule

/* hw/shell_ctrl.sv */
`timescale 1ns/1ps

module shell_ctrl import shell_pkg::*; (
	input  logic       clock_49,
	input  logic       arst_n,
	input  logic       ioctl_download,
	input  logic [7:0] status,
	input  logic [1:0] buttons,
	input  logic [1:0] core_mod,
	output logic       core_reset,
	output logic       led,
	output logic       rot_tick,
	output logic       bootleg
);

	logic                    download_d;
	logic                    rom_loaded;
	logic [ROT_DIV_SLOW-1:0] rot_div;

	// core stays in reset until a full image has been loaded
	always_ff @(posedge clock_49 or negedge arst_n) begin
		if (!arst_n) begin
			download_d <= 1'b0;
			rom_loaded <= 1'b0;
			core_reset <= 1'b1;
		end else begin
			download_d <= ioctl_download;
			if (download_d && !ioctl_download) begin
				rom_loaded <= 1'b1;
			end
			core_reset <= status[0] | buttons[1] | ~rom_loaded;
		end
	end

	always_ff @(posedge clock_49 or negedge arst_n) begin
		if (!arst_n) begin
			rot_div <= '0;
		end else begin
			rot_div <= rot_div + 1'b1;
		end
	end

	// status bit 1 selects the fast step rate
	assign rot_tick = status[1] ? (rot_div[ROT_DIV_FAST-1:0] == '0) : (rot_div == '0);

	assign bootleg = (core_mod == BOOTLEG_MOD);

	// lit while no download is running
	assign led = ~ioctl_download;

endmodule

/* common/rom_wr_if.sv */
`timescale 1ns/1ps

interface rom_wr_if import shell_pkg::*; ();

	logic              we;
	logic [GFX_AW-1:0] addr;
	// lane enables, bit 1 is the high byte
	logic [1:0]        ds;
	logic [15:0]       data;

	modport src (
		output we, addr, ds, data
	);

	modport dst (
		input we, addr, ds, data
	);

endinterface

/* common/shell_pkg.sv */
package shell_pkg;

	// bank geometry, scaled down from the board sizes
	localparam int CPU_AW = 10;
	localparam int GFX_AW = 10;

	// download byte address width and start of the graphics region
	localparam int DL_AW = 12;
	localparam int GFX_BASE = 2048;

	// offset bit that picks the graphics plane
	localparam int GFX_LANE_BIT = 10;

	// rotary step dividers, normal and fast
	localparam int ROT_DIV_SLOW = 8;
	localparam int ROT_DIV_FAST = 6;

	// rotary home position, one-hot
	localparam logic [7:0] ROT_HOME = 8'h01;

	// core_mod value of the bootleg sets, which have no rotary hardware
	localparam logic [1:0] BOOTLEG_MOD = 2'b01;

	// even byte in the low lane, odd byte in the high lane
	typedef logic [15:0] cpu_word_t;

	// two graphics planes merged into one word
	typedef struct packed {
		logic [7:0] plane_hi;
		logic [7:0] plane_lo;
	} gfx_word_t;

endpackage
